//--- Bender.yml
package:
  name: ysyx_bus

sources:
  - logic/ysyx_bus_pkg.sv
  - logic/ysyx_lsu.sv
  - logic/ysyx_arbiter.sv
  - logic/ysyx_xbar.sv
  - logic/ysyx_clint.sv
  - logic/ysyx_bus_top.sv
  - target: simulation
    files:
      - sim/ysyx_bus_assert.sv
      - sim/tb_ysyx_bus.sv

//--- logic/ysyx_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ysyx_arbiter (
	input  wire                    clock,
	input  wire                    rst_i,

	input  wire                    fetch_valid_i,
	input  wire [31:0]             fetch_addr_i,
	output logic                   fetch_ready_o,
	output ysyx_bus_pkg::bus_rsp_t fetch_rsp_o,

	input  ysyx_bus_pkg::bus_req_t lsu_req_i,
	output logic                   lsu_ready_o,
	output ysyx_bus_pkg::bus_rsp_t lsu_rsp_o,

	output ysyx_bus_pkg::bus_req_t bus_req_o,
	input  wire                    bus_ready_i,
	input  ysyx_bus_pkg::bus_rsp_t bus_rsp_i
);

	ysyx_bus_pkg::bus_req_t fetch_req;
	logic                   gnt_data;
	logic                   gnt_fetch;
	logic                   busy_q;
	// high when the data port owns the outstanding transfer
	logic                   owner_q;

	// fetch is always a plain word read
	always_comb begin
		fetch_req       = '0;
		fetch_req.valid = fetch_valid_i;
		fetch_req.addr  = fetch_addr_i;
	end

	// ------------------------------
	// grant, data first
	// ------------------------------
	assign gnt_data  = !busy_q && lsu_req_i.valid;
	assign gnt_fetch = !busy_q && !lsu_req_i.valid && fetch_valid_i;

	always_comb begin
		bus_req_o = '0;
		if (gnt_data) begin
			bus_req_o = lsu_req_i;
		end else if (gnt_fetch) begin
			bus_req_o = fetch_req;
		end
	end

	assign lsu_ready_o   = gnt_data && bus_ready_i;
	assign fetch_ready_o = gnt_fetch && bus_ready_i;

	// locked from acceptance until the response
	always_ff @(posedge clock) begin
		if (rst_i) begin
			busy_q  <= 1'b0;
			owner_q <= 1'b0;
		end else if (bus_req_o.valid && bus_ready_i) begin
			busy_q  <= 1'b1;
			owner_q <= gnt_data;
		end else if (bus_rsp_i.valid) begin
			busy_q  <= 1'b0;
		end
	end

	// ------------------------------
	// response steering
	// ------------------------------
	always_comb begin
		fetch_rsp_o       = bus_rsp_i;
		lsu_rsp_o         = bus_rsp_i;
		fetch_rsp_o.valid = bus_rsp_i.valid && busy_q && !owner_q;
		lsu_rsp_o.valid   = bus_rsp_i.valid && busy_q && owner_q;
	end

endmodule

`default_nettype wire

//--- logic/ysyx_bus_pkg.sv
`default_nettype none

package ysyx_bus_pkg;

	// ------------------------------
	// address map defaults
	// ------------------------------
	// an address hits when (addr & MASK) == (BASE & MASK)
	localparam logic [31:0] CLINT_BASE = 32'h0200_0000;
	localparam logic [31:0] CLINT_MASK = 32'hffff_0000;
	localparam logic [31:0] MEM_BASE   = 32'h8000_0000;
	localparam logic [31:0] MEM_MASK   = 32'hf000_0000;

	// ------------------------------
	// shared bus
	// ------------------------------
	typedef struct packed {
		logic        valid;
		logic        write;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
	} bus_req_t;

	// single-cycle valid pulse, always accepted
	typedef struct packed {
		logic        valid;
		logic        err;
		logic [31:0] rdata;
	} bus_rsp_t;

	// ------------------------------
	// data port
	// ------------------------------
	typedef enum logic [1:0] {
		size_byte = 2'd0,
		size_half = 2'd1,
		size_word = 2'd2
	} acc_size_e;

	typedef struct packed {
		logic        valid;
		logic        write;
		acc_size_e   size;
		logic        load_unsigned;
		logic [31:0] addr;
		logic [31:0] wdata;
	} data_req_t;

	// ------------------------------
	// timer
	// ------------------------------
	typedef struct packed {
		logic [31:0] hi;
		logic [31:0] lo;
	} mtime_half_t;

	// counted as one word, read back as two halves
	typedef union packed {
		logic [63:0] word;
		mtime_half_t half;
	} mtime_u;

endpackage

`default_nettype wire

//--- logic/ysyx_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module ysyx_bus_top #(
	parameter logic [31:0] CLINT_BASE = ysyx_bus_pkg::CLINT_BASE,
	parameter logic [31:0] CLINT_MASK = ysyx_bus_pkg::CLINT_MASK,
	parameter logic [31:0] MEM_BASE   = ysyx_bus_pkg::MEM_BASE,
	parameter logic [31:0] MEM_MASK   = ysyx_bus_pkg::MEM_MASK
) (
	input  wire                     clock,
	input  wire                     rst_i,

	// ------------------------------
	// instruction fetch
	// ------------------------------
	input  wire                     fetch_valid_i,
	input  wire [31:0]              fetch_addr_i,
	output logic                    fetch_ready_o,
	output ysyx_bus_pkg::bus_rsp_t  fetch_rsp_o,

	// ------------------------------
	// load/store
	// ------------------------------
	input  ysyx_bus_pkg::data_req_t data_req_i,
	output logic                    data_ready_o,
	output ysyx_bus_pkg::bus_rsp_t  data_rsp_o,

	// ------------------------------
	// external memory
	// ------------------------------
	output ysyx_bus_pkg::bus_req_t  mem_req_o,
	input  wire                     mem_ready_i,
	input  ysyx_bus_pkg::bus_rsp_t  mem_rsp_i
);

	ysyx_bus_pkg::bus_req_t lsu_req;
	ysyx_bus_pkg::bus_rsp_t lsu_rsp;
	logic                   lsu_ready;
	ysyx_bus_pkg::bus_req_t bus_req;
	ysyx_bus_pkg::bus_rsp_t bus_rsp;
	logic                   bus_ready;
	ysyx_bus_pkg::bus_req_t clint_req;
	ysyx_bus_pkg::bus_rsp_t clint_rsp;

	ysyx_lsu u_lsu (
		.clock        (clock),
		.rst_i        (rst_i),
		.data_req_i   (data_req_i),
		.data_ready_o (data_ready_o),
		.data_rsp_o   (data_rsp_o),
		.lsu_req_o    (lsu_req),
		.lsu_ready_i  (lsu_ready),
		.lsu_rsp_i    (lsu_rsp)
	);

	// fetch and lsu share the bus here
	ysyx_arbiter u_arbiter (
		.clock         (clock),
		.rst_i         (rst_i),
		.fetch_valid_i (fetch_valid_i),
		.fetch_addr_i  (fetch_addr_i),
		.fetch_ready_o (fetch_ready_o),
		.fetch_rsp_o   (fetch_rsp_o),
		.lsu_req_i     (lsu_req),
		.lsu_ready_o   (lsu_ready),
		.lsu_rsp_o     (lsu_rsp),
		.bus_req_o     (bus_req),
		.bus_ready_i   (bus_ready),
		.bus_rsp_i     (bus_rsp)
	);

	ysyx_xbar #(
		.CLINT_BASE (CLINT_BASE),
		.CLINT_MASK (CLINT_MASK),
		.MEM_BASE   (MEM_BASE),
		.MEM_MASK   (MEM_MASK)
	) u_xbar (
		.clock       (clock),
		.rst_i       (rst_i),
		.bus_req_i   (bus_req),
		.bus_ready_o (bus_ready),
		.bus_rsp_o   (bus_rsp),
		.clint_req_o (clint_req),
		.clint_rsp_i (clint_rsp),
		.mem_req_o   (mem_req_o),
		.mem_ready_i (mem_ready_i),
		.mem_rsp_i   (mem_rsp_i)
	);

	ysyx_clint u_clint (
		.clock       (clock),
		.rst_i       (rst_i),
		.clint_req_i (clint_req),
		.clint_rsp_o (clint_rsp)
	);

endmodule

`default_nettype wire

//--- logic/ysyx_clint.sv
`timescale 1ns/1ps
`default_nettype none

module ysyx_clint (
	input  wire                    clock,
	input  wire                    rst_i,

	input  ysyx_bus_pkg::bus_req_t clint_req_i,
	output ysyx_bus_pkg::bus_rsp_t clint_rsp_o
);

	ysyx_bus_pkg::mtime_u mtime_q;
	logic                 rsp_valid_q;
	logic [31:0]          rdata_q;

	// free running, no compare or write port
	always_ff @(posedge clock) begin
		if (rst_i) begin
			mtime_q.word <= 64'h0;
		end else begin
			mtime_q.word <= mtime_q.word + 64'h1;
		end
	end

	always_ff @(posedge clock) begin
		if (rst_i) begin
			rsp_valid_q <= 1'b0;
		end else begin
			rsp_valid_q <= clint_req_i.valid;
		end
	end

	// addr bit 2 picks the upper half
	always_ff @(posedge clock) begin
		if (clint_req_i.valid) begin
			rdata_q <= clint_req_i.addr[2] ? mtime_q.half.hi : mtime_q.half.lo;
		end
	end

	assign clint_rsp_o.valid = rsp_valid_q;
	assign clint_rsp_o.err   = 1'b0;
	assign clint_rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

//--- logic/ysyx_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module ysyx_lsu (
	input  wire                     clock,
	input  wire                     rst_i,

	input  ysyx_bus_pkg::data_req_t data_req_i,
	output logic                    data_ready_o,
	output ysyx_bus_pkg::bus_rsp_t  data_rsp_o,

	output ysyx_bus_pkg::bus_req_t  lsu_req_o,
	input  wire                     lsu_ready_i,
	input  ysyx_bus_pkg::bus_rsp_t  lsu_rsp_i
);

	logic [1:0]              req_off;
	logic [1:0]              off_q;
	ysyx_bus_pkg::acc_size_e size_q;
	logic                    unsigned_q;
	logic [31:0]             rdata_sh;

	assign req_off = data_req_i.addr[1:0];

	// ------------------------------
	// request path
	// ------------------------------
	always_comb begin
		lsu_req_o.valid = data_req_i.valid;
		lsu_req_o.write = data_req_i.write;
		lsu_req_o.addr  = {data_req_i.addr[31:2], 2'b00};
		// move the store data onto its byte lane
		lsu_req_o.wdata = data_req_i.wdata << {req_off, 3'b000};
		lsu_req_o.wstrb = 4'b0000;
		if (data_req_i.write) begin
			case (data_req_i.size)
				ysyx_bus_pkg::size_byte: lsu_req_o.wstrb = 4'b0001 << req_off;
				ysyx_bus_pkg::size_half: lsu_req_o.wstrb = 4'b0011 << req_off;
				default:                 lsu_req_o.wstrb = 4'b1111;
			endcase
		end
	end

	assign data_ready_o = lsu_ready_i;

	// keep what the load needs until its data comes back
	always_ff @(posedge clock) begin
		if (rst_i) begin
			off_q      <= 2'b00;
			size_q     <= ysyx_bus_pkg::size_word;
			unsigned_q <= 1'b0;
		end else if (data_req_i.valid && lsu_ready_i) begin
			off_q      <= req_off;
			size_q     <= data_req_i.size;
			unsigned_q <= data_req_i.load_unsigned;
		end
	end

	// ------------------------------
	// response path
	// ------------------------------
	assign rdata_sh = lsu_rsp_i.rdata >> {off_q, 3'b000};

	always_comb begin
		data_rsp_o.valid = lsu_rsp_i.valid;
		data_rsp_o.err   = lsu_rsp_i.err;
		case (size_q)
			ysyx_bus_pkg::size_byte:
				data_rsp_o.rdata = unsigned_q ? {24'h0, rdata_sh[7:0]}
				                              : {{24{rdata_sh[7]}}, rdata_sh[7:0]};
			ysyx_bus_pkg::size_half:
				data_rsp_o.rdata = unsigned_q ? {16'h0, rdata_sh[15:0]}
				                              : {{16{rdata_sh[15]}}, rdata_sh[15:0]};
			default:
				data_rsp_o.rdata = rdata_sh;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/ysyx_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module ysyx_xbar #(
	parameter logic [31:0] CLINT_BASE = ysyx_bus_pkg::CLINT_BASE,
	parameter logic [31:0] CLINT_MASK = ysyx_bus_pkg::CLINT_MASK,
	parameter logic [31:0] MEM_BASE   = ysyx_bus_pkg::MEM_BASE,
	parameter logic [31:0] MEM_MASK   = ysyx_bus_pkg::MEM_MASK
) (
	input  wire                    clock,
	input  wire                    rst_i,

	input  ysyx_bus_pkg::bus_req_t bus_req_i,
	output logic                   bus_ready_o,
	output ysyx_bus_pkg::bus_rsp_t bus_rsp_o,

	output ysyx_bus_pkg::bus_req_t clint_req_o,
	input  ysyx_bus_pkg::bus_rsp_t clint_rsp_i,

	output ysyx_bus_pkg::bus_req_t mem_req_o,
	input  wire                    mem_ready_i,
	input  ysyx_bus_pkg::bus_rsp_t mem_rsp_i
);

	logic hit_clint;
	logic hit_mem;
	logic fault_q;

	// ------------------------------
	// address decode
	// ------------------------------
	assign hit_clint = (bus_req_i.addr & CLINT_MASK) == (CLINT_BASE & CLINT_MASK);
	assign hit_mem   = !hit_clint && ((bus_req_i.addr & MEM_MASK) == (MEM_BASE & MEM_MASK));

	always_comb begin
		clint_req_o       = bus_req_i;
		clint_req_o.valid = bus_req_i.valid && hit_clint;
		mem_req_o         = bus_req_i;
		mem_req_o.valid   = bus_req_i.valid && hit_mem;
	end

	// only the external port can stall
	assign bus_ready_o = hit_mem ? mem_ready_i : 1'b1;

	// unmapped access, answered one cycle later
	always_ff @(posedge clock) begin
		if (rst_i) begin
			fault_q <= 1'b0;
		end else begin
			fault_q <= bus_req_i.valid && !hit_clint && !hit_mem;
		end
	end

	// ------------------------------
	// response merge
	// ------------------------------
	always_comb begin
		bus_rsp_o.valid = mem_rsp_i.valid || clint_rsp_i.valid || fault_q;
		bus_rsp_o.err   = (mem_rsp_i.valid && mem_rsp_i.err)
		                  || (clint_rsp_i.valid && clint_rsp_i.err) || fault_q;
		if (mem_rsp_i.valid) begin
			bus_rsp_o.rdata = mem_rsp_i.rdata;
		end else if (clint_rsp_i.valid) begin
			bus_rsp_o.rdata = clint_rsp_i.rdata;
		end else begin
			bus_rsp_o.rdata = 32'h0;
		end
	end

endmodule

`default_nettype wire

//--- sim/tb_ysyx_bus.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ysyx_bus;

	localparam logic [31:0] MEM_BASE   = ysyx_bus_pkg::MEM_BASE;
	localparam logic [31:0] CLINT_BASE = ysyx_bus_pkg::CLINT_BASE;
	localparam int          WAIT_LIMIT = 200;

	typedef struct packed {
		logic        chk;
		logic        err;
		logic [31:0] rdata;
	} exp_t;

	logic                    clock = 1'b0;
	logic                    rst_i;
	logic                    fetch_valid_i;
	logic [31:0]             fetch_addr_i;
	logic                    fetch_ready_o;
	ysyx_bus_pkg::bus_rsp_t  fetch_rsp_o;
	ysyx_bus_pkg::data_req_t data_req_i;
	logic                    data_ready_o;
	ysyx_bus_pkg::bus_rsp_t  data_rsp_o;
	ysyx_bus_pkg::bus_req_t  mem_req_o;
	logic                    mem_ready_i;
	ysyx_bus_pkg::bus_rsp_t  mem_rsp_i;

	int          seed = 32'h94dd71b0;
	logic [31:0] mem    [0:255];
	logic [31:0] shadow [0:255];
	logic        mem_pend;
	int          mem_wait;
	logic [31:0] mem_rdata;
	exp_t        exp_fetch [$];
	exp_t        exp_data  [$];
	int          fetch_rsp_cnt = 0;
	int          data_rsp_cnt = 0;
	int          rsp_seq = 0;
	int          fetch_seq = 0;
	int          data_seq = 0;
	logic [31:0] last_data_rdata;
	logic        no_mem_watch;

	always #5 clock = ~clock;

	ysyx_bus_top #(
		.CLINT_BASE (ysyx_bus_pkg::CLINT_BASE),
		.CLINT_MASK (ysyx_bus_pkg::CLINT_MASK),
		.MEM_BASE   (ysyx_bus_pkg::MEM_BASE),
		.MEM_MASK   (ysyx_bus_pkg::MEM_MASK)
	) u_ysyx_bus_top (
		.clock         (clock),
		.rst_i         (rst_i),
		.fetch_valid_i (fetch_valid_i),
		.fetch_addr_i  (fetch_addr_i),
		.fetch_ready_o (fetch_ready_o),
		.fetch_rsp_o   (fetch_rsp_o),
		.data_req_i    (data_req_i),
		.data_ready_o  (data_ready_o),
		.data_rsp_o    (data_rsp_o),
		.mem_req_o     (mem_req_o),
		.mem_ready_i   (mem_ready_i),
		.mem_rsp_i     (mem_rsp_i)
	);

	// ------------------------------
	// helpers and reference model
	// ------------------------------
	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string msg);
		abort_run($sformatf("CHECK FAILED at time %0t: %s", $time, msg));
	endtask

	function automatic exp_t make_exp(input logic chk, input logic err, input logic [31:0] v);
		exp_t e;
		e.chk   = chk;
		e.err   = err;
		e.rdata = v;
		return e;
	endfunction

	// initial memory word mixed from the full address
	function automatic logic [31:0] fill_word(input logic [31:0] a);
		return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
	endfunction

	function automatic ysyx_bus_pkg::acc_size_e pick_size(input logic [1:0] v);
		if (v == 2'd0) begin
			return ysyx_bus_pkg::size_byte;
		end else if (v == 2'd1) begin
			return ysyx_bus_pkg::size_half;
		end
		return ysyx_bus_pkg::size_word;
	endfunction

	function automatic logic [31:0] align_addr(input logic [31:0] a,
			input ysyx_bus_pkg::acc_size_e sz);
		case (sz)
			ysyx_bus_pkg::size_byte: return a;
			ysyx_bus_pkg::size_half: return {a[31:1], 1'b0};
			default:                 return {a[31:2], 2'b00};
		endcase
	endfunction

	// expected load value from the shadow copy
	function automatic logic [31:0] load_ref(input logic [31:0] addr,
			input ysyx_bus_pkg::acc_size_e sz, input logic uns);
		logic [31:0] w;
		logic [7:0]  b;
		logic [15:0] h;
		w = shadow[addr[9:2]];
		b = w[addr[1:0] * 8 +: 8];
		h = w[addr[1] * 16 +: 16];
		case (sz)
			ysyx_bus_pkg::size_byte: return uns ? {24'h0, b} : {{24{b[7]}}, b};
			ysyx_bus_pkg::size_half: return uns ? {16'h0, h} : {{16{h[15]}}, h};
			default:                 return w;
		endcase
	endfunction

	// byte i of the store data lands at byte offset+i
	task automatic shadow_store(input logic [31:0] addr, input ysyx_bus_pkg::acc_size_e sz,
			input logic [31:0] data);
		int n;
		int i;
		n = (sz == ysyx_bus_pkg::size_byte) ? 1 : (sz == ysyx_bus_pkg::size_half) ? 2 : 4;
		for (i = 0; i < n; i++) begin
			shadow[addr[9:2]][(addr[1:0] + i) * 8 +: 8] = data[i * 8 +: 8];
		end
	endtask

	// ------------------------------
	// port drivers
	// ------------------------------
	task automatic fetch_read(input logic [31:0] addr, input exp_t want);
		int   t;
		int   start;
		logic done;
		start = fetch_rsp_cnt;
		exp_fetch.push_back(want);
		fetch_valid_i = 1'b1;
		fetch_addr_i  = addr;
		t    = 0;
		done = 1'b0;
		while (!done) begin
			@(posedge clock);
			done = fetch_ready_o;
			t++;
			if (!done && t > WAIT_LIMIT) begin
				abort_run("timeout waiting for fetch_ready_o");
			end
		end
		#1;
		fetch_valid_i = 1'b0;
		t = 0;
		while (fetch_rsp_cnt == start) begin
			@(posedge clock);
			t++;
			if (t > WAIT_LIMIT) begin
				abort_run("timeout waiting for a fetch response");
			end
		end
		#1;
	endtask

	task automatic data_access(input logic wr, input ysyx_bus_pkg::acc_size_e sz,
			input logic uns, input logic [31:0] addr, input logic [31:0] wdata,
			input exp_t want, output logic [31:0] rdata);
		int   t;
		int   start;
		logic done;
		start = data_rsp_cnt;
		exp_data.push_back(want);
		data_req_i.valid         = 1'b1;
		data_req_i.write         = wr;
		data_req_i.size          = sz;
		data_req_i.load_unsigned = uns;
		data_req_i.addr          = addr;
		data_req_i.wdata         = wdata;
		t    = 0;
		done = 1'b0;
		while (!done) begin
			@(posedge clock);
			done = data_ready_o;
			t++;
			if (!done && t > WAIT_LIMIT) begin
				abort_run("timeout waiting for data_ready_o");
			end
		end
		#1;
		data_req_i = '0;
		t = 0;
		while (data_rsp_cnt == start) begin
			@(posedge clock);
			t++;
			if (t > WAIT_LIMIT) begin
				abort_run("timeout waiting for a data response");
			end
		end
		#1;
		rdata = last_data_rdata;
	endtask

	task automatic store_data(input logic [31:0] addr, input ysyx_bus_pkg::acc_size_e sz,
			input logic [31:0] wdata);
		logic [31:0] rd;
		shadow_store(addr, sz, wdata);
		data_access(1'b1, sz, 1'b0, addr, wdata, make_exp(1'b0, 1'b0, 32'h0), rd);
	endtask

	task automatic load_data(input logic [31:0] addr, input ysyx_bus_pkg::acc_size_e sz,
			input logic uns, output logic [31:0] rd);
		data_access(1'b0, sz, uns, addr, 32'h0, make_exp(1'b1, 1'b0, load_ref(addr, sz, uns)),
			rd);
	endtask

	// ------------------------------
	// external memory model
	// ------------------------------
	always @(posedge clock) begin : mem_model
		int   r;
		int   b;
		logic rsp_now;
		logic ready_next;
		rsp_now = 1'b0;
		if (rst_i) begin
			mem_pend = 1'b0;
		end else begin
			if (mem_pend) begin
				if (mem_wait == 1) begin
					rsp_now  = 1'b1;
					mem_pend = 1'b0;
				end else begin
					mem_wait--;
				end
			end
			if (mem_req_o.valid && mem_ready_i) begin
				assert (mem_req_o.addr[31:10] == MEM_BASE[31:10])
				else abort_run("memory request outside the modeled window");
				r         = $random(seed);
				mem_pend  = 1'b1;
				mem_wait  = 1 + (r & 3);
				mem_rdata = 32'h0;
				if (mem_req_o.write) begin
					for (b = 0; b < 4; b++) begin
						if (mem_req_o.wstrb[b]) begin
							mem[mem_req_o.addr[9:2]][b * 8 +: 8] = mem_req_o.wdata[b * 8 +: 8];
						end
					end
				end else begin
					mem_rdata = mem[mem_req_o.addr[9:2]];
				end
			end
		end
		// ready high about three cycles in four
		r = $random(seed);
		ready_next = (r[1:0] != 2'b00);
		#1;
		mem_ready_i     = ready_next;
		mem_rsp_i.valid = rsp_now;
		mem_rsp_i.err   = 1'b0;
		mem_rsp_i.rdata = rsp_now ? mem_rdata : 32'h0;
	end

	// ------------------------------
	// response checker
	// ------------------------------
	always @(posedge clock) begin : compare_rsp
		exp_t e;
		if (!rst_i) begin
			assert (u_ysyx_bus_top.u_bus_assert.fail_cnt == 0)
			else abort_run("a bus protocol assertion failed");
			if (no_mem_watch) begin
				assert (!mem_req_o.valid)
				else report_mismatch("mem_req_o.valid raised during an unmapped access");
			end
			if (fetch_rsp_o.valid) begin
				assert (exp_fetch.size() != 0)
				else abort_run("fetch response arrived with no fetch outstanding");
				e = exp_fetch.pop_front();
				assert (fetch_rsp_o.err == e.err)
				else report_mismatch($sformatf("fetch err %0b, expected %0b",
					fetch_rsp_o.err, e.err));
				assert (!e.chk || fetch_rsp_o.rdata == e.rdata)
				else report_mismatch($sformatf("fetch rdata %h, expected %h",
					fetch_rsp_o.rdata, e.rdata));
				fetch_rsp_cnt <= fetch_rsp_cnt + 1;
				fetch_seq     <= rsp_seq;
			end
			if (data_rsp_o.valid) begin
				assert (exp_data.size() != 0)
				else abort_run("data response arrived with no data access outstanding");
				e = exp_data.pop_front();
				assert (data_rsp_o.err == e.err)
				else report_mismatch($sformatf("data err %0b, expected %0b",
					data_rsp_o.err, e.err));
				assert (!e.chk || data_rsp_o.rdata == e.rdata)
				else report_mismatch($sformatf("data rdata %h, expected %h",
					data_rsp_o.rdata, e.rdata));
				last_data_rdata <= data_rsp_o.rdata;
				data_rsp_cnt    <= data_rsp_cnt + 1;
				data_seq        <= rsp_seq;
			end
			if (fetch_rsp_o.valid || data_rsp_o.valid) begin
				rsp_seq <= rsp_seq + 1;
			end
		end
	end

	// ------------------------------
	// stimulus
	// ------------------------------
	initial begin
		int                        i;
		int                        n;
		int                        r;
		logic [31:0]               a;
		logic [31:0]               rd;
		logic [31:0]               lo_first;
		logic [31:0]               lo_second;
		ysyx_bus_pkg::acc_size_e   sz;
		rst_i         = 1'b1;
		fetch_valid_i = 1'b0;
		fetch_addr_i  = 32'h0;
		data_req_i    = '0;
		mem_ready_i   = 1'b0;
		mem_rsp_i     = '0;
		no_mem_watch  = 1'b0;
		for (i = 0; i < 256; i++) begin
			mem[i]    = fill_word(MEM_BASE + i * 4);
			shadow[i] = fill_word(MEM_BASE + i * 4);
		end
		repeat (3) @(posedge clock);
		#1;
		rst_i = 1'b0;

		// plain fetches from the start of memory
		for (i = 0; i < 4; i++) begin
			a = MEM_BASE + i * 4;
			fetch_read(a, make_exp(1'b1, 1'b0, load_ref(a, ysyx_bus_pkg::size_word, 1'b0)));
		end

		// two timer lo reads then the hi half that is still zero this early
		data_access(1'b0, ysyx_bus_pkg::size_word, 1'b0, CLINT_BASE, 32'h0,
			make_exp(1'b0, 1'b0, 32'h0), lo_first);
		data_access(1'b0, ysyx_bus_pkg::size_word, 1'b0, CLINT_BASE, 32'h0,
			make_exp(1'b0, 1'b0, 32'h0), lo_second);
		assert (lo_second > lo_first)
		else report_mismatch($sformatf("mtime lo went from %0d to %0d",
			lo_first, lo_second));
		data_access(1'b0, ysyx_bus_pkg::size_word, 1'b0, CLINT_BASE + 32'h4, 32'h0,
			make_exp(1'b1, 1'b0, 32'h0), rd);
		// writes are dropped but still answered
		data_access(1'b1, ysyx_bus_pkg::size_word, 1'b0, CLINT_BASE, 32'h1234_5678,
			make_exp(1'b0, 1'b0, 32'h0), rd);

		// random stores and loads in a small window
		for (n = 0; n < 40; n++) begin
			r  = $random(seed);
			sz = pick_size(r[1:0]);
			a  = align_addr(MEM_BASE + 32'h100 + {26'h0, r[9:4]}, sz);
			if (r[12]) begin
				store_data(a, sz, $random(seed));
			end else begin
				load_data(a, sz, r[13], rd);
			end
		end

		// data wins when both ports ask in the same cycle
		fork
			fetch_read(MEM_BASE + 32'h40,
				make_exp(1'b1, 1'b0, load_ref(MEM_BASE + 32'h40, ysyx_bus_pkg::size_word, 1'b0)));
			load_data(MEM_BASE + 32'h80, ysyx_bus_pkg::size_word, 1'b0, rd);
		join
		assert (data_seq < fetch_seq)
		else report_mismatch("fetch response came before the data response");

		// unmapped accesses
		no_mem_watch = 1'b1;
		data_access(1'b0, ysyx_bus_pkg::size_word, 1'b0, 32'h4000_0010, 32'h0,
			make_exp(1'b1, 1'b1, 32'h0), rd);
		fetch_read(32'h4000_0020, make_exp(1'b1, 1'b1, 32'h0));
		no_mem_watch = 1'b0;

		// mixed traffic while memory keeps stalling
		for (n = 0; n < 30; n++) begin
			r  = $random(seed);
			sz = pick_size(r[1:0]);
			a  = align_addr(MEM_BASE + 32'h100 + {26'h0, r[9:4]}, sz);
			case (r[13:12])
				2'd0: fetch_read({a[31:2], 2'b00}, make_exp(1'b1, 1'b0,
					load_ref({a[31:2], 2'b00}, ysyx_bus_pkg::size_word, 1'b0)));
				2'd1: store_data(a, sz, $random(seed));
				default: load_data(a, sz, r[14], rd);
			endcase
		end

		repeat (5) @(posedge clock);
		assert (exp_fetch.size() == 0 && exp_data.size() == 0)
		else abort_run("some requests never got a response");
		if (u_ysyx_bus_top.u_bus_assert.fail_cnt == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			abort_run("a bus protocol assertion failed");
		end
	end

endmodule

`default_nettype wire

//--- sim/ysyx_bus_assert.sv
`timescale 1ns/1ps
`default_nettype none

module ysyx_bus_assert (
	input  wire                    clock,
	input  wire                    rst_i,

	input  ysyx_bus_pkg::bus_req_t mem_req_i,
	input  wire                    mem_ready_i,

	input  ysyx_bus_pkg::bus_req_t bus_req_i,
	input  wire                    bus_ready_i,
	input  ysyx_bus_pkg::bus_rsp_t bus_rsp_i
);

	logic        out_q;
	int unsigned fail_cnt = 0;

	// one transfer in flight on the shared bus
	always_ff @(posedge clock) begin
		if (rst_i) begin
			out_q <= 1'b0;
		end else if (bus_req_i.valid && bus_ready_i) begin
			out_q <= 1'b1;
		end else if (bus_rsp_i.valid) begin
			out_q <= 1'b0;
		end
	end

	// ------------------------------
	// protocol rules
	// ------------------------------
	mem_req_held: assert property (@(posedge clock) disable iff (rst_i)
		mem_req_i.valid && !mem_ready_i |=> mem_req_i.valid && $stable(mem_req_i))
	else begin
		$error("mem_req_o changed while the memory stalled");
		fail_cnt++;
	end

	single_outstanding: assert property (@(posedge clock) disable iff (rst_i)
		out_q |-> !(bus_req_i.valid && bus_ready_i))
	else begin
		$error("second request accepted while one is outstanding");
		fail_cnt++;
	end

	// a response needs an accepted request before it
	rsp_after_req: assert property (@(posedge clock) disable iff (rst_i)
		bus_rsp_i.valid |-> out_q)
	else begin
		$error("bus response with no accepted request");
		fail_cnt++;
	end

endmodule

bind ysyx_bus_top ysyx_bus_assert u_bus_assert (
	.clock       (clock),
	.rst_i       (rst_i),
	.mem_req_i   (mem_req_o),
	.mem_ready_i (mem_ready_i),
	.bus_req_i   (bus_req),
	.bus_ready_i (bus_ready),
	.bus_rsp_i   (bus_rsp)
);

`default_nettype wire

//--- src.f
logic/ysyx_bus_pkg.sv
logic/ysyx_lsu.sv
logic/ysyx_arbiter.sv
logic/ysyx_xbar.sv
logic/ysyx_clint.sv
logic/ysyx_bus_top.sv
sim/ysyx_bus_assert.sv
sim/tb_ysyx_bus.sv
